// ==== rtl/l1Cache_defs.svh ====
// L1 cache geometry
`ifndef L1CACHE_DEFS_SVH
`define L1CACHE_DEFS_SVH

// Word address, no byte lanes
`define ADDR_W 32

// Data word carried on both CPU and L2 sides
`define WORD_W 32

// 16 sets
`define INDEX_W 4

// 4 words per line
`define OFFSET_W 2

// Words per line, follows the offset width
`define LINE_WORDS (1 << `OFFSET_W)

// Whatever is left above index and offset
`define TAG_W (`ADDR_W - `INDEX_W - `OFFSET_W)

// Sets per way
`define NUM_SETS (1 << `INDEX_W)

`endif

// ==== rtl/l1CachePkg.sv ====
// L1 cache types
`include "l1Cache_defs.svh"

package l1CachePkg;

    // Meaningful widths
    typedef logic [`ADDR_W-1:0]     addrT;      // Word address
    typedef logic [`WORD_W-1:0]     wordT;      // Data word
    typedef logic [`TAG_W-1:0]      tagT;       // Upper address bits kept per line
    typedef logic [`INDEX_W-1:0]    indexT;     // Set select
    typedef logic [`OFFSET_W-1:0]   offsetT;    // Word within line
    typedef logic [`LINE_WORDS-1:0] dirtyMaskT; // One dirty bit per word

    // Main request machine
    typedef enum logic [1:0] {
        ready,          // Serving hits, detecting misses
        waitWriteback,  // Victim dirty words going out to L2
        waitRefill      // Line words coming in from L2
    } missStateT;

    // Writeback drain machine
    typedef enum logic {
        searching,      // Looking for the lowest dirty word
        waitSending     // L2 still storing the last word
    } wbStateT;

endpackage

// ==== rtl/tagDataStore.sv ====
// Two-way tag and data store
`timescale 1ns/1ns
`include "l1Cache_defs.svh"

module tagDataStore (
    input  logic                  clk,
    input  logic                  rst,
    input  l1CachePkg::addrT      cpuAddr,
    input  l1CachePkg::wordT      cpuWrData,
    input  logic                  cpuWriteStrobe,   // Write hit into hit way
    input  logic                  touchStrobe,      // Served hit, update LRU
    input  logic                  refillStrobe,     // One refill word into victim way
    input  logic                  lineCommit,       // Last refill word, line becomes valid
    input  l1CachePkg::offsetT    refillPos,
    input  l1CachePkg::wordT      refillData,
    input  logic                  clearDirty,       // Word has been sent to L2
    input  l1CachePkg::offsetT    clearPos,
    input  l1CachePkg::offsetT    victimPos,        // Read position for writeback data
    output logic                  hit,
    output logic                  hitWay,
    output l1CachePkg::wordT      hitWord,
    output logic                  victimWay,
    output l1CachePkg::dirtyMaskT victimDirty,
    output l1CachePkg::tagT       victimTag,
    output l1CachePkg::wordT      victimWord
);

    // Request address fields
    l1CachePkg::tagT    reqTag;
    l1CachePkg::indexT  reqIndex;
    l1CachePkg::offsetT reqOffset;

    logic way0Hit;
    logic way1Hit;

    // Storage, first dimension is the way
    l1CachePkg::tagT       tagMem   [2][`NUM_SETS];
    logic                  validMem [2][`NUM_SETS];
    l1CachePkg::dirtyMaskT dirtyMem [2][`NUM_SETS];
    l1CachePkg::wordT      dataMem  [2][`NUM_SETS][`LINE_WORDS];
    logic                  lruMem   [`NUM_SETS];       // Way to evict next

    assign reqOffset = cpuAddr[`OFFSET_W-1:0];
    assign reqIndex  = cpuAddr[`OFFSET_W +: `INDEX_W];
    assign reqTag    = cpuAddr[`ADDR_W-1 -: `TAG_W];

    // A way hits when valid and tag matches, each way checked on its own
    assign way0Hit = validMem[0][reqIndex] && (tagMem[0][reqIndex] == reqTag);
    assign way1Hit = validMem[1][reqIndex] && (tagMem[1][reqIndex] == reqTag);

    assign hit     = way0Hit || way1Hit;
    assign hitWay  = way1Hit;                                   // Way 0 unless way 1 matched
    assign hitWord = dataMem[hitWay][reqIndex][reqOffset];     // Read data, same cycle

    // Victim side, all driven from the LRU bit of the set
    assign victimWay   = lruMem[reqIndex];
    assign victimTag   = tagMem[victimWay][reqIndex];
    assign victimWord  = dataMem[victimWay][reqIndex][victimPos];
    assign victimDirty = validMem[victimWay][reqIndex] ? dirtyMem[victimWay][reqIndex] : '0;

    // Valid, dirty and LRU state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `NUM_SETS; s++) begin
                validMem[0][s] <= 1'b0;
                validMem[1][s] <= 1'b0;
                dirtyMem[0][s] <= '0;
                dirtyMem[1][s] <= '0;
                lruMem[s]      <= 1'b0;                        // Evict way 0 first
            end
        end else begin
            if (cpuWriteStrobe) begin
                dirtyMem[hitWay][reqIndex][reqOffset] <= 1'b1;
            end
            if (touchStrobe) begin
                lruMem[reqIndex] <= ~hitWay;                   // Other way is now oldest
            end
            if (clearDirty) begin
                dirtyMem[victimWay][reqIndex][clearPos] <= 1'b0;
            end
            if (refillStrobe) begin
                validMem[victimWay][reqIndex]            <= 1'b0; // Old line is gone
                dirtyMem[victimWay][reqIndex][refillPos] <= 1'b0; // Fresh word from L2
            end
            if (lineCommit) begin
                validMem[victimWay][reqIndex] <= 1'b1;         // Overrides the clear above
            end
        end
    end

    // Data words and tags
    always_ff @(posedge clk) begin
        if (cpuWriteStrobe) begin
            dataMem[hitWay][reqIndex][reqOffset] <= cpuWrData;
        end
        if (refillStrobe) begin
            dataMem[victimWay][reqIndex][refillPos] <= refillData;
        end
        if (lineCommit) begin
            tagMem[victimWay][reqIndex] <= reqTag;
        end
    end

endmodule

// ==== rtl/writebackEngine.sv ====
// Victim writeback engine
`timescale 1ns/1ns
`include "l1Cache_defs.svh"

module writebackEngine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  drainReq,     // Miss needs the victim cleaned
    input  logic                  l2Busy,       // L2 still storing a word
    input  l1CachePkg::dirtyMaskT victimDirty,
    input  l1CachePkg::tagT       victimTag,
    input  l1CachePkg::wordT      victimWord,
    input  l1CachePkg::addrT      cpuAddr,
    output l1CachePkg::offsetT    victimPos,    // Lowest dirty word
    output logic                  clearDirty,
    output l1CachePkg::offsetT    clearPos,
    output logic                  l2Write,
    output l1CachePkg::addrT      l2WrAddr,
    output l1CachePkg::wordT      l2WrData,
    output logic                  wbPending     // Drain not finished
);

    l1CachePkg::wbStateT state;
    l1CachePkg::wbStateT stateNext;
    l1CachePkg::indexT   reqIndex;
    logic                anyDirty;

    assign reqIndex = cpuAddr[`OFFSET_W +: `INDEX_W];
    assign anyDirty = |victimDirty;

    // Priority pick, loop runs downward so the lowest set bit wins
    always_comb begin
        victimPos = '0;
        for (int i = `LINE_WORDS - 1; i >= 0; i--) begin
            if (victimDirty[i]) begin
                victimPos = l1CachePkg::offsetT'(i);
            end
        end
    end

    // State register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= l1CachePkg::searching;
        end else begin
            state <= stateNext;
        end
    end

    // Next state
    always_comb begin
        stateNext = state;
        case (state)
            l1CachePkg::searching: begin
                if (drainReq && anyDirty) begin
                    stateNext = l1CachePkg::waitSending;   // Word goes out this cycle
                end
            end
            l1CachePkg::waitSending: begin
                if (!l2Busy) begin
                    stateNext = l1CachePkg::searching;     // L2 free for the next word
                end
            end
            default: stateNext = l1CachePkg::searching;
        endcase
    end

    // One-cycle write pulse, dirty bit cleared on the same edge
    assign l2Write    = (state == l1CachePkg::searching) && drainReq && anyDirty;
    assign clearDirty = l2Write;
    assign clearPos   = victimPos;

    // Word address rebuilt from the victim tag and the request set
    assign l2WrAddr = {victimTag, reqIndex, victimPos};
    assign l2WrData = victimWord;

    // Still draining while dirty words remain or L2 is busy with the last one
    assign wbPending = anyDirty || (state == l1CachePkg::waitSending);

endmodule

// ==== rtl/missController.sv ====
// Miss sequencing controller
`timescale 1ns/1ns
`include "l1Cache_defs.svh"

module missController (
    input  logic               clk,
    input  logic               rst,
    input  logic               readEn,
    input  logic               writeEn,
    input  logic               hit,
    input  logic               wbPending,     // Victim drain still running
    input  logic               refillValid,   // L2 word present this cycle
    input  l1CachePkg::offsetT refillPos,
    output logic               stall,
    output logic               l2Read,
    output logic               drainReq,
    output logic               cpuWriteStrobe,
    output logic               touchStrobe,
    output logic               refillStrobe,
    output logic               lineCommit
);

    l1CachePkg::missStateT state;
    l1CachePkg::missStateT stateNext;
    logic                  request;
    logic                  served;
    logic                  missSeen;
    logic                  lastWord;

    assign request  = readEn || writeEn;
    assign served   = (state == l1CachePkg::ready) && request && hit;
    assign missSeen = (state == l1CachePkg::ready) && request && !hit;
    assign lastWord = (refillPos == l1CachePkg::offsetT'(`LINE_WORDS - 1));

    // State register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= l1CachePkg::ready;
        end else begin
            state <= stateNext;
        end
    end

    // Next state
    always_comb begin
        stateNext = state;
        case (state)
            l1CachePkg::ready: begin
                if (missSeen) begin
                    if (wbPending) begin
                        stateNext = l1CachePkg::waitWriteback; // Dirty victim first
                    end else begin
                        stateNext = l1CachePkg::waitRefill;    // Clean victim, fetch now
                    end
                end
            end
            l1CachePkg::waitWriteback: begin
                if (!wbPending) begin
                    stateNext = l1CachePkg::waitRefill;
                end
            end
            l1CachePkg::waitRefill: begin
                if (refillValid && lastWord) begin
                    stateNext = l1CachePkg::ready;             // Request hits next cycle
                end
            end
            default: stateNext = l1CachePkg::ready;
        endcase
    end

    // CPU side
    assign stall          = request && !served;           // Any unserved request waits
    assign touchStrobe    = served;
    assign cpuWriteStrobe = served && writeEn;             // Marks the word dirty too

    // Writeback engine runs from the miss cycle until the drain ends
    assign drainReq = missSeen || (state == l1CachePkg::waitWriteback);

    // Refill side, L2 read held for the whole collection
    assign l2Read       = (state == l1CachePkg::waitRefill);
    assign refillStrobe = l2Read && refillValid;
    assign lineCommit   = refillStrobe && lastWord;

endmodule

// ==== rtl/l1Cache.sv ====
// L1 data cache top
`timescale 1ns/1ns
`include "l1Cache_defs.svh"

module l1Cache (
    input  logic               clk,
    input  logic               rst,
    input  logic               readEn,
    input  logic               writeEn,
    input  l1CachePkg::addrT   cpuAddr,
    input  l1CachePkg::wordT   cpuWrData,
    input  logic               refillValid,
    input  logic               l2Busy,
    input  l1CachePkg::offsetT refillPos,
    input  l1CachePkg::wordT   refillData,
    output l1CachePkg::wordT   readData,
    output logic               stall,
    output logic               l2Read,
    output logic               l2Write,
    output l1CachePkg::addrT   l2Addr,
    output l1CachePkg::wordT   l2WrData
);

    // Store lookup results
    logic                  hit;
    l1CachePkg::dirtyMaskT victimDirty;
    l1CachePkg::tagT       victimTag;
    l1CachePkg::wordT      victimWord;

    // Store update strobes
    logic                  cpuWriteStrobe;
    logic                  touchStrobe;
    logic                  refillStrobe;
    logic                  lineCommit;
    logic                  clearDirty;
    l1CachePkg::offsetT    clearPos;
    l1CachePkg::offsetT    victimPos;

    // Between the two machines
    logic                  drainReq;
    logic                  wbPending;
    l1CachePkg::addrT      l2WrAddr;
    l1CachePkg::addrT      lineBase;

    assign lineBase = {cpuAddr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}}; // Refill starts at word 0
    assign l2Addr   = l2Write ? l2WrAddr : lineBase;

    tagDataStore store (
        .clk(clk),
        .rst(rst),
        .cpuAddr(cpuAddr),
        .cpuWrData(cpuWrData),
        .cpuWriteStrobe(cpuWriteStrobe),
        .touchStrobe(touchStrobe),
        .refillStrobe(refillStrobe),
        .lineCommit(lineCommit),
        .refillPos(refillPos),
        .refillData(refillData),
        .clearDirty(clearDirty),
        .clearPos(clearPos),
        .victimPos(victimPos),
        .hit(hit),
        .hitWay(),
        .hitWord(readData),
        .victimWay(),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .victimWord(victimWord)
    );

    missController ctrl (
        .clk(clk),
        .rst(rst),
        .readEn(readEn),
        .writeEn(writeEn),
        .hit(hit),
        .wbPending(wbPending),
        .refillValid(refillValid),
        .refillPos(refillPos),
        .stall(stall),
        .l2Read(l2Read),
        .drainReq(drainReq),
        .cpuWriteStrobe(cpuWriteStrobe),
        .touchStrobe(touchStrobe),
        .refillStrobe(refillStrobe),
        .lineCommit(lineCommit)
    );

    writebackEngine wb (
        .clk(clk),
        .rst(rst),
        .drainReq(drainReq),
        .l2Busy(l2Busy),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .victimWord(victimWord),
        .cpuAddr(cpuAddr),
        .victimPos(victimPos),
        .clearDirty(clearDirty),
        .clearPos(clearPos),
        .l2Write(l2Write),
        .l2WrAddr(l2WrAddr),
        .l2WrData(l2WrData),
        .wbPending(wbPending)
    );

endmodule

// ==== tests/l1Cache_asserts.sv ====
// L1 cache protocol checks
`timescale 1ns/1ns

module l1CacheAsserts (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic l2Read,
    input logic l2Write,
    input logic l2Busy
);

    int failures = 0;                              // Read by the testbench at the end

    noReadWrite: assert property (@(posedge clk) disable iff (rst) !(l2Read && l2Write))
        else begin $error("l2Read and l2Write high in the same cycle"); failures++; end

    writePulse: assert property (@(posedge clk) disable iff (rst) l2Write |=> !l2Write)
        else begin $error("l2Write held longer than one cycle"); failures++; end

    // L2 must be free before the next word goes out
    writeWhenFree: assert property (@(posedge clk) disable iff (rst) !(l2Write && l2Busy))
        else begin $error("l2Write issued while l2Busy was high"); failures++; end

    idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !stall)
        else begin $error("stall high in the first cycle after reset"); failures++; end

endmodule

bind l1Cache l1CacheAsserts checks (
    .clk(clk), .rst(rst), .stall(stall), .l2Read(l2Read), .l2Write(l2Write), .l2Busy(l2Busy)
);

// ==== tests/l1CacheTb.sv ====
// L1 cache testbench
`timescale 1ns/1ns

module l1CacheTb;

    logic               clk;
    logic               rst;
    logic               readEn;
    logic               writeEn;
    l1CachePkg::addrT   cpuAddr;
    l1CachePkg::wordT   cpuWrData;
    logic               refillValid;
    logic               l2Busy;
    l1CachePkg::offsetT refillPos;
    l1CachePkg::wordT   refillData;
    l1CachePkg::wordT   readData;
    logic               stall;
    logic               l2Read;
    logic               l2Write;
    l1CachePkg::addrT   l2Addr;
    l1CachePkg::wordT   l2WrData;

    integer           seed = 32'h540c11e3;          // Busy lengths and refill gaps
    l1CachePkg::wordT memWords [l1CachePkg::addrT]; // Only words written back by the cache

    l1Cache uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                     // 10 ns period
    end

    // L2 content with untouched words following the fill rule
    function automatic l1CachePkg::wordT memRead(input l1CachePkg::addrT addr);
        if (memWords.exists(addr)) begin
            return memWords[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic abortRun(input string why);
        $display("%0s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on first error");
    endtask

    // Hold one request until the cache stops stalling
    task automatic doRequest(input logic isWrite, input l1CachePkg::addrT addr,
                             input l1CachePkg::wordT data, output l1CachePkg::wordT result);
        int waited;
        waited    = 0;
        readEn    = !isWrite;
        writeEn   = isWrite;
        cpuAddr   = addr;
        cpuWrData = data;
        @(negedge clk);                            // Stall is combinational so look mid-cycle
        while (stall) begin
            waited++;
            if (waited > 200) begin
                abortRun($sformatf("Timeout: stall never fell for address %h", addr));
            end
            @(negedge clk);
        end
        result = readData;
        @(posedge clk);                            // Request taken at this edge
        #1;
        readEn  = 1'b0;
        writeEn = 1'b0;
    endtask

    // L2 model samples mid-cycle and drives 1 ns after the edge
    initial begin : l2Model
        int               busyLeft;
        int               refillIdx;
        logic             sendWord;
        logic             lineDone;
        l1CachePkg::wordT nextData;
        refillValid = 1'b0;
        l2Busy      = 1'b0;
        refillPos   = '0;
        refillData  = '0;
        busyLeft    = 0;
        refillIdx   = 0;                           // Next word of the line to send
        forever begin
            @(negedge clk);
            lineDone = 1'b0;
            if (busyLeft > 0) busyLeft--;
            if (l2Write) begin
                memWords[l2Addr] = l2WrData;
                busyLeft = 1 + ($random(seed) & 3); // 1 to 4 busy cycles
            end
            if (refillValid && l2Read) begin
                refillIdx++;                       // Word taken at the coming edge
                if (refillIdx == 4) begin          // Whole line delivered
                    refillIdx = 0;
                    lineDone  = 1'b1;
                end
            end
            sendWord = l2Read && !lineDone && (($random(seed) & 1) == 0); // Random gaps
            nextData = memRead(l2Addr + l1CachePkg::addrT'(refillIdx));
            @(posedge clk);
            #1;
            l2Busy      = (busyLeft > 0);
            refillValid = sendWord;
            refillPos   = l1CachePkg::offsetT'(refillIdx);
            refillData  = nextData;
        end
    end

    initial begin : replay
        int               fd;
        int               fields;
        int               vectorCount;
        string            lineText;
        logic [8*16-1:0]  testName;
        logic [3:0]       op;
        l1CachePkg::addrT addr;
        l1CachePkg::wordT wrData;
        l1CachePkg::wordT expData;
        l1CachePkg::wordT result;
        rst         = 1'b1;
        readEn      = 1'b0;
        writeEn     = 1'b0;
        cpuAddr     = '0;
        cpuWrData   = '0;
        vectorCount = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);                            // First cycle after reset stays idle
        #1;
        fd = $fopen("tests/l1Cache_vectors.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the vector file tests/l1Cache_vectors.txt");
        end
        while ($fgets(lineText, fd) != 0) begin
            if (lineText.len() < 8 || lineText[0] == "#") begin
                continue;                          // Column notes and blank lines
            end
            fields = $sscanf(lineText, "%s %h %h %h %h", testName, op, addr, wrData, expData);
            if (fields != 5) begin
                abortRun($sformatf("Malformed vector line: %0s", lineText));
            end
            doRequest(op == 4'h1, addr, wrData, result);
            vectorCount++;
            if (op == 4'h0) begin
                assert (result == expData) else begin
                    abortRun($sformatf("[FAIL] %0s: expected %h, actual %h",
                                       testName, expData, result));
                end
            end
        end
        $fclose(fd);
        repeat (2) @(posedge clk);                 // Let the bound checks see the last cycles
        if (vectorCount > 0 && uut.checks.failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("Run ended with %0d vectors and %0d protocol check failures",
                     vectorCount, uut.checks.failures);
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/l1CachePkg.sv
rtl/tagDataStore.sv
rtl/writebackEngine.sv
rtl/missController.sv
rtl/l1Cache.sv
tests/l1Cache_asserts.sv
tests/l1CacheTb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns -Mdir obj_dir \
    --top-module l1CacheTb -f compile.f &&
./obj_dir/Vl1CacheTb +verilator+error+limit+100 | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tests/l1Cache_vectors.txt ====
# name op addr wrData expData, all hex except name
# op 0 reads and checks expData, op 1 writes wrData and ignores expData
cold0 0 00000100 00000000 a5a50100
cold1 0 00000101 00000000 a5a50101
cold2 0 00000102 00000000 a5a50102
cold3 0 00000103 00000000 a5a50103
wrHit 1 00000101 12345678 00000000
rdHit 0 00000101 00000000 12345678
nbr0 0 00000100 00000000 a5a50100
nbr2 0 00000102 00000000 a5a50102
lruA 0 00000014 00000000 a5a50014
lruB 0 00000054 00000000 a5a50054
lruTouch 0 00000014 00000000 a5a50014
lruC 0 00000094 00000000 a5a50094
lruKeep 0 00000015 00000000 a5a50015
lruBack 0 00000056 00000000 a5a50056
dirty0 1 00000024 dead0001 00000000
dirty2 1 00000026 dead0003 00000000
evictE 0 00000064 00000000 a5a50064
evictF 0 000000a4 00000000 a5a500a4
wbBack0 0 00000024 00000000 dead0001
wbBack1 0 00000025 00000000 a5a50025
wbBack2 0 00000026 00000000 dead0003
wrMiss 1 00000203 cafef00d 00000000
wmWord 0 00000203 00000000 cafef00d
wmOld0 0 00000200 00000000 a5a50200
wmOld2 0 00000202 00000000 a5a50202
conflict 0 00000300 00000000 a5a50300
wbOld 0 00000101 00000000 12345678
wbNew 0 00000203 00000000 cafef00d
